//--- baud_bank_top.f
verilog/baud_pkg.sv
verilog/brg_if.sv
verilog/baud_reg_decode.sv
verilog/baud_rate_gen.sv
verilog/baud_tick_collect.sv
verilog/baud_bank_top.sv
testbench/tb_baud_bank.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the baud bank testbench with Verilator.
# Exit status is nonzero when the build fails or the run reports failure.

cd "$(dirname "$0")" || exit 1

OBJ_DIR=obj_dir
LOG=sim.log
TOP=tb_baud_bank

verilator --binary --timing --assert \
  --top-module "$TOP" \
  -f baud_bank_top.f \
  -Mdir "$OBJ_DIR" \
  -o "$TOP"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$OBJ_DIR/$TOP" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

if grep -q "Result: FAILED" "$LOG"; then
  exit 1
fi

if ! grep -q "Result: PASSED" "$LOG"; then
  echo "No result line found in $LOG"
  exit 1
fi

exit 0

//--- testbench/tb_baud_bank.sv
`timescale 1ns/1ps

module tb_baud_bank;
  import baud_pkg::*;

  // DUT ports
  logic                br_clk;
  logic                rst;
  logic                wr;
  ch_sel_t             addr;
  byte_en_t            be;
  rate_t               d;
  rate_t               rd;
  tick_cnt_t           tick_cnt;
  logic [NUM_CH-1:0]   rce;
  logic [NUM_CH-1:0]   rclk;

  // Result bookkeeping
  int errors;
  int checks;
  int test_no;
  int test_base;

  // Reference model state, cycle k is the interval after edge k
  int        cyc;
  rate_t     exp_rate [NUM_CH];
  tick_cnt_t exp_tick [NUM_CH];
  // Edge of the last divisor write and the one before it
  int        last_n   [NUM_CH];
  int        prev_n   [NUM_CH];
  rate_t     last_r   [NUM_CH];
  rate_t     prev_r   [NUM_CH];
  // rce pulses since the last write, rclk highs since the last pulse
  int        pulses   [NUM_CH];
  int        hi_cnt   [NUM_CH];

  baud_bank_top DUT (
    .br_clk   (br_clk),
    .rst      (rst),
    .wr       (wr),
    .addr     (addr),
    .be       (be),
    .d        (d),
    .rd       (rd),
    .tick_cnt (tick_cnt),
    .rce      (rce),
    .rclk     (rclk)
  );

  // 40 ns clock
  initial begin
    br_clk = 1'b0;
    forever #20 br_clk = ~br_clk;
  end

  // ------------------------------------------------------------------
  // Reference functions
  // ------------------------------------------------------------------

  // Byte-enabled merge into a divisor register
  function automatic rate_t merge_bytes(rate_t old, byte_en_t b, rate_t val);
    rate_t r;
    r = old;
    if (b[1]) r[15:8] = val[15:8];
    if (b[0]) r[7:0] = val[7:0];
    return r;
  endfunction

  // rce in cycle c for a divisor r written at edge n
  // Pulses fall R edges after the write edge, then every R cycles
  function automatic logic sched_rce(int c, int n, rate_t r);
    if (r == '0 || c <= n) return 1'b0;
    return ((c - n) % int'(r)) == 0;
  endfunction

  // Old schedule still runs in the reload cycle itself
  function automatic logic exp_rce_at(int ch, int c);
    if (c <= last_n[ch]) return sched_rce(c, prev_n[ch], prev_r[ch]);
    return sched_rce(c, last_n[ch], last_r[ch]);
  endfunction

  // rclk high cycles per period
  function automatic rate_t duty_high(rate_t r);
    return r - (r >> 1);
  endfunction

  function automatic rate_t rand_divisor();
    return rate_t'(2 + ($urandom % 39));
  endfunction

  // ------------------------------------------------------------------
  // Compare tasks
  // ------------------------------------------------------------------

  task automatic check_rate(string name, rate_t got, rate_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t: %s got 0x%h expected 0x%h", $time, name, got, exp);
    end
  endtask

  task automatic check_tick(string name, tick_cnt_t got, tick_cnt_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t: %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_vec(string name, logic [NUM_CH-1:0] got, logic [NUM_CH-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  // ------------------------------------------------------------------
  // Model update on each rising edge
  // ------------------------------------------------------------------

  always @(posedge br_clk) begin
    if (rst) begin
      cyc = 0;
      for (int i = 0; i < NUM_CH; i++) begin
        exp_rate[i] = '0;
        exp_tick[i] = '0;
        last_n[i]   = -10;
        prev_n[i]   = -10;
        last_r[i]   = '0;
        prev_r[i]   = '0;
        pulses[i]   = 0;
      end
    end else begin
      cyc = cyc + 1;
      // Ticks for the cycle that just ended, clear wins
      for (int i = 0; i < NUM_CH; i++) begin
        if (cyc - 1 == last_n[i]) exp_tick[i] = '0;
        else if (exp_rce_at(i, cyc - 1)) exp_tick[i] = exp_tick[i] + tick_cnt_t'(1);
        // Pulses of the current divisor only
        if (cyc - 1 > last_n[i] && exp_rce_at(i, cyc - 1)) pulses[i]++;
      end
      // A write with no byte enabled changes nothing
      if (wr && be != 2'b00) begin
        exp_rate[addr] = merge_bytes(exp_rate[addr], be, d);
        prev_n[addr]   = last_n[addr];
        prev_r[addr]   = last_r[addr];
        last_n[addr]   = cyc;
        last_r[addr]   = exp_rate[addr];
        pulses[addr]   = 0;
      end
    end
  end

  // ------------------------------------------------------------------
  // Monitor, samples mid-cycle
  // ------------------------------------------------------------------

  always @(negedge br_clk) begin
    logic [NUM_CH-1:0] exp_vec;
    logic [NUM_CH-1:0] zero_mask;
    if (rst) begin
      for (int i = 0; i < NUM_CH; i++) begin
        hi_cnt[i] = 0;
      end
    end else begin
      for (int i = 0; i < NUM_CH; i++) begin
        exp_vec[i]   = exp_rce_at(i, cyc);
        // Zero divisor holds rclk low once the load has passed through
        zero_mask[i] = (last_r[i] == '0) && (cyc >= last_n[i] + 2);
      end
      check_vec("rce", rce, exp_vec);
      check_vec("rclk on zero divisor", rclk & zero_mask, '0);
      check_rate($sformatf("rd ch%0d", addr), rd, exp_rate[addr]);
      check_tick($sformatf("tick_cnt ch%0d", addr), tick_cnt, exp_tick[addr]);
      for (int i = 0; i < NUM_CH; i++) begin
        hi_cnt[i] = hi_cnt[i] + (rclk[i] ? 1 : 0);
        if (exp_vec[i] && cyc > last_n[i]) begin
          // First window after a load holds the old count
          if (pulses[i] >= 1) begin
            check_rate($sformatf("rclk high cycles ch%0d", i), rate_t'(hi_cnt[i]),
                       duty_high(last_r[i]));
          end
          hi_cnt[i] = 0;
        end
      end
    end
  end

  // ------------------------------------------------------------------
  // Stimulus tasks
  // ------------------------------------------------------------------

  task automatic next_cycle();
    @(posedge br_clk);
    #2;
  endtask

  task automatic write_reg(ch_sel_t ch, byte_en_t b, rate_t val);
    wr   = 1'b1;
    addr = ch;
    be   = b;
    d    = val;
    next_cycle();
    wr   = 1'b0;
  endtask

  task automatic end_run();
    $display("Tests: %0d, checks: %0d, errors: %0d", test_no - 1, checks, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  endtask

  task automatic timeout_fail(string what);
    $display("Timeout in test %0d while waiting for %s", test_no, what);
    errors++;
  endtask

  task automatic finish_test(string name);
    $display("Test %0d (%s) done, %0d errors", test_no, name, errors - test_base);
    test_no++;
    test_base = errors;
  endtask

  // Selected channels reach a number of rce pulses
  task automatic wait_pulses(logic [NUM_CH-1:0] sel, int need, int limit);
    int  t;
    logic done;
    t    = 0;
    done = 1'b0;
    while (!done && t < limit) begin
      done = 1'b1;
      for (int i = 0; i < NUM_CH; i++) begin
        if (sel[i] && pulses[i] < need) done = 1'b0;
      end
      if (!done) begin
        next_cycle();
        t++;
      end
    end
    if (!done) timeout_fail("rce periods");
  endtask

  task automatic wait_ticks(int ch, int need, int limit);
    int t;
    t = 0;
    while (int'(exp_tick[ch]) < need && t < limit) begin
      next_cycle();
      t++;
    end
    if (int'(exp_tick[ch]) < need) timeout_fail("tick count");
  endtask

  // ------------------------------------------------------------------
  // Tests
  // ------------------------------------------------------------------

  initial begin
    errors    = 0;
    checks    = 0;
    test_no   = 1;
    test_base = 0;
    void'($urandom(32'hcac3_8bf5));
    rst  = 1'b1;
    wr   = 1'b0;
    addr = '0;
    be   = '0;
    d    = '0;
    repeat (4) @(posedge br_clk);
    #2;
    rst = 1'b0;

    // Quiet after reset, every channel read back
    for (int i = 0; i < 20; i++) begin
      addr = ch_sel_t'(i % NUM_CH);
      next_cycle();
    end
    finish_test("reset state");

    // Random byte enables, some back to back
    repeat (16) begin
      write_reg(ch_sel_t'($urandom % NUM_CH), byte_en_t'($urandom % 4), rate_t'($urandom));
    end
    for (int i = 0; i < NUM_CH; i++) begin
      addr = ch_sel_t'(i);
      next_cycle();
    end
    finish_test("byte enable writes");

    // All channels at once, 6 checked periods each
    for (int i = 0; i < NUM_CH; i++) write_reg(ch_sel_t'(i), 2'b11, rand_divisor());
    wait_pulses('1, 7, 7 * 40 + 80);
    finish_test("rce period");

    // New divisors for the duty check
    for (int i = 0; i < NUM_CH; i++) write_reg(ch_sel_t'(i), 2'b11, rand_divisor());
    wait_pulses('1, 5, 5 * 40 + 80);
    finish_test("rclk duty");

    // Divide by 1, divide by 0, restart mid-period
    write_reg(2'd0, 2'b11, rate_t'(1));
    write_reg(2'd1, 2'b11, rate_t'(0));
    write_reg(2'd2, 2'b11, rate_t'(20));
    write_reg(2'd3, 2'b11, rate_t'(3));
    wait_pulses(4'b0100, 2, 100);
    repeat (1 + ($urandom % 15)) next_cycle();
    write_reg(2'd2, 2'b01, rate_t'(7));
    wait_pulses(4'b0101, 4, 100);
    finish_test("edge divisors");

    // Tick counts, cleared by a rewrite
    write_reg(2'd3, 2'b11, rate_t'(5));
    for (int i = 0; i < 12; i++) begin
      addr = ch_sel_t'(i % NUM_CH);
      next_cycle();
    end
    addr = 2'd3;
    wait_ticks(3, 10, 200);
    write_reg(2'd3, 2'b11, rate_t'(9));
    addr = 2'd3;
    wait_ticks(3, 3, 100);
    finish_test("tick count");

    end_run();
  end

endmodule : tb_baud_bank

//--- verilog/baud_bank_top.sv
`timescale 1ns/1ps

module baud_bank_top (
  input  logic                         br_clk,
  input  logic                         rst,
  input  logic                         wr,
  input  baud_pkg::ch_sel_t            addr,
  input  baud_pkg::byte_en_t           be,
  input  baud_pkg::rate_t              d,
  output baud_pkg::rate_t              rd,
  output baud_pkg::tick_cnt_t          tick_cnt,
  output logic [baud_pkg::NUM_CH-1:0]  rce,
  output logic [baud_pkg::NUM_CH-1:0]  rclk
);
  import baud_pkg::*;

  // ------------------------------------------------------------------
  // Internal bus
  // ------------------------------------------------------------------

  brg_if bus ();

  // ------------------------------------------------------------------
  // Host registers
  // ------------------------------------------------------------------

  baud_reg_decode u_decode (
    .br_clk (br_clk),
    .rst    (rst),
    .wr     (wr),
    .addr   (addr),
    .be     (be),
    .d      (d),
    .rd     (rd),
    .bus    (bus.ctrl)
  );

  // ------------------------------------------------------------------
  // Generators, one per channel
  // ------------------------------------------------------------------

  for (genvar g = 0; g < NUM_CH; g++) begin : g_ch
    baud_rate_gen #(
      .CH (g)
    ) u_gen (
      .br_clk (br_clk),
      .rst    (rst),
      .bus    (bus.gen)
    );
  end

  // Tick counters
  baud_tick_collect u_collect (
    .br_clk   (br_clk),
    .rst      (rst),
    .addr     (addr),
    .bus      (bus.mon),
    .tick_cnt (tick_cnt)
  );

  // Per-channel outputs straight off the bus
  assign rce  = bus.rce;
  assign rclk = bus.rclk;

endmodule : baud_bank_top

//--- verilog/baud_tick_collect.sv
`timescale 1ns/1ps

module baud_tick_collect (
  input  logic                br_clk,
  input  logic                rst,
  input  baud_pkg::ch_sel_t   addr,
  brg_if.mon                  bus,
  output baud_pkg::tick_cnt_t tick_cnt
);
  import baud_pkg::*;

  // Tick counters, one per channel
  tick_cnt_t  cnt_q   [NUM_CH];
  // Armed by the first reload
  clr_state_t state_q [NUM_CH];

  // ------------------------------------------------------------------
  // Per-channel counting
  // ------------------------------------------------------------------

  always_ff @(posedge br_clk or posedge rst) begin
    if (rst) begin
      for (int i = 0; i < NUM_CH; i++) begin
        cnt_q[i]   <= '0;
        state_q[i] <= CLR_IDLE;
      end
    end else begin
      for (int i = 0; i < NUM_CH; i++) begin
        // Reload clears, wins over a same-edge tick
        if (bus.reload[i]) begin
          cnt_q[i]   <= '0;
          state_q[i] <= CLR_RUN;
        end else begin
          case (state_q[i])
            CLR_IDLE: begin
              // Never programmed, hold at zero
              cnt_q[i] <= '0;
            end
            CLR_RUN: begin
              if (bus.rce[i]) cnt_q[i] <= cnt_q[i] + tick_cnt_t'(1);
            end
            default: begin
              state_q[i] <= CLR_IDLE;
            end
          endcase
        end
      end
    end
  end

  // ------------------------------------------------------------------
  // Readback
  // ------------------------------------------------------------------

  // Combinational select, no read strobe
  assign tick_cnt = cnt_q[addr];

endmodule : baud_tick_collect

//--- verilog/baud_rate_gen.sv
`timescale 1ns/1ps

module baud_rate_gen #(
  parameter int CH = 0
) (
  input logic br_clk,
  input logic rst,
  brg_if.gen  bus
);
  import baud_pkg::*;

  // This channel's divisor
  rate_t rate;
  // Down-counter, runs R..1
  rate_t count_q;
  // Load on reload or terminal count
  logic  load;
  // Divide by 0 or 1 holds the count
  logic  dec_en;
  // Terminal count
  logic  rce;
  // Half-period clock
  logic  rclk_q;

  assign rate = bus.rate[CH];

  // ------------------------------------------------------------------
  // Down-counter
  // ------------------------------------------------------------------

  assign rce    = (count_q == rate_t'(1));
  assign load   = bus.reload[CH] || rce;
  assign dec_en = (rate > rate_t'(1));

  always_ff @(posedge br_clk or posedge rst) begin
    if (rst) begin
      count_q <= '0;
    end else if (load) begin
      count_q <= rate;
    end else if (dec_en) begin
      count_q <= count_q - rate_t'(1);
    end
  end

  // ------------------------------------------------------------------
  // Receive clock
  // ------------------------------------------------------------------

  // High for the upper part of the count, one cycle late
  always_ff @(posedge br_clk or posedge rst) begin
    if (rst) begin
      rclk_q <= 1'b0;
    end else begin
      rclk_q <= (count_q > (rate >> 1));
    end
  end

  assign bus.rce[CH]  = rce;
  assign bus.rclk[CH] = rclk_q;

  // ------------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------------

  // Outside the reload cycle the register equals the last loaded divisor
  a_rce_nonzero : assert property (
    @(posedge br_clk) disable iff (rst)
    (bus.rce[CH] && !bus.reload[CH]) |-> (rate != '0)
  ) else $error("ch%0d rce with zero divisor", CH);

  a_count_range : assert property (
    @(posedge br_clk) disable iff (rst)
    !bus.reload[CH] |-> (count_q <= rate)
  ) else $error("ch%0d count above loaded divisor", CH);

endmodule : baud_rate_gen

//--- verilog/baud_reg_decode.sv
`timescale 1ns/1ps

module baud_reg_decode (
  input  logic               br_clk,
  input  logic               rst,
  input  logic               wr,
  input  baud_pkg::ch_sel_t  addr,
  input  baud_pkg::byte_en_t be,
  input  baud_pkg::rate_t    d,
  output baud_pkg::rate_t    rd,
  brg_if.ctrl                bus
);
  import baud_pkg::*;

  // Per-channel byte loads
  logic [NUM_CH-1:0] ub_ld;
  logic [NUM_CH-1:0] lb_ld;
  // Divisor registers
  rate_t             rate_q [NUM_CH];
  // Registered reload pulse
  logic [NUM_CH-1:0] reload_q;

  // ------------------------------------------------------------------
  // Write decode
  // ------------------------------------------------------------------

  always_comb begin
    for (int i = 0; i < NUM_CH; i++) begin
      // Upper byte only when be[1] set for the addressed channel
      ub_ld[i] = wr && (addr == ch_sel_t'(i)) && be[1];
      lb_ld[i] = wr && (addr == ch_sel_t'(i)) && be[0];
    end
  end

  // ------------------------------------------------------------------
  // Divisor registers and reload pulse
  // ------------------------------------------------------------------

  always_ff @(posedge br_clk or posedge rst) begin
    if (rst) begin
      for (int i = 0; i < NUM_CH; i++) begin
        rate_q[i] <= '0;
      end
      reload_q <= '0;
    end else begin
      for (int i = 0; i < NUM_CH; i++) begin
        // Bytes merge independently
        if (ub_ld[i]) rate_q[i][RATE_W-1:8] <= d[RATE_W-1:8];
        if (lb_ld[i]) rate_q[i][7:0] <= d[7:0];
      end
      // Any byte written restarts that channel next edge
      reload_q <= ub_ld | lb_ld;
    end
  end

  assign bus.rate   = rate_q;
  assign bus.reload = reload_q;

  // Host readback, combinational by address
  assign rd = rate_q[addr];

  // ------------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------------

  // Back-to-back reload only from back-to-back host writes
  for (genvar g = 0; g < NUM_CH; g++) begin : g_chk
    a_reload_from_wr : assert property (
      @(posedge br_clk) disable iff (rst)
      (bus.reload[g] && $past(bus.reload[g])) |-> $past(wr)
    ) else $error("reload[%0d] held without a host write", g);
  end

endmodule : baud_reg_decode

//--- verilog/brg_if.sv
`timescale 1ns/1ps

interface brg_if;
  import baud_pkg::*;

  // Divisor per channel, held by the decoder
  rate_t             rate [NUM_CH];
  // One-cycle reload request after a host write
  logic [NUM_CH-1:0] reload;
  // Terminal count strobes, one bit per generator
  logic [NUM_CH-1:0] rce;
  // Half-duty baud clocks, one bit per generator
  logic [NUM_CH-1:0] rclk;

  // Register decoder side
  modport ctrl (
    output rate,
    output reload
  );

  // Generator side, each instance drives only its own bit
  modport gen (
    input  rate,
    input  reload,
    output rce,
    output rclk
  );

  // Tick collector side
  modport mon (
    input reload,
    input rce
  );

endinterface : brg_if

//--- verilog/baud_pkg.sv
package baud_pkg;

  // ------------------------------------------------------------------
  // Bank dimensions
  // ------------------------------------------------------------------

  // Channels in the bank
  localparam int NUM_CH = 4;
  // Channel address width
  localparam int CH_W   = $clog2(NUM_CH);
  // Divisor and down-counter width
  localparam int RATE_W = 16;
  // Per-channel tick counter width
  localparam int TICK_W = 16;

  // ------------------------------------------------------------------
  // Types
  // ------------------------------------------------------------------

  // Divisor, also the range of the down-counter
  typedef logic [RATE_W-1:0] rate_t;
  // Tick count, wraps at the top
  typedef logic [TICK_W-1:0] tick_cnt_t;
  // Host channel select
  typedef logic [CH_W-1:0]   ch_sel_t;
  // Bit 1 upper byte, bit 0 lower byte
  typedef logic [1:0]        byte_en_t;

  // Collector per-channel state
  // Idle until the first reload so unprogrammed channels read zero
  typedef enum logic {
    CLR_IDLE = 1'b0,
    CLR_RUN  = 1'b1
  } clr_state_t;

endpackage : baud_pkg
